// ==== verilog/core_pkg.sv ====
package core_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// basic types.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef logic [31:0] word;
	typedef logic [3:0]  reg_num;

	localparam reg_num reg_lr = 4'd14;
	localparam reg_num reg_pc = 4'd15;

	typedef struct packed {
		logic n;
		logic z;
		logic c;
		logic v;
	} psr_flags;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_orr,
		alu_mov,
		alu_mul
	} alu_op;

	typedef enum logic [1:0] {
		kind_alu,
		kind_mul,
		kind_ldm
	} insn_kind;

	// exactly one bit is set at a time.
	typedef struct packed {
		logic issue;
		logic transfer;
		logic base_writeback;
		logic exception;
		logic mul;
		logic mul_hi_wb;
	} ctrl_cycle;

	localparam ctrl_cycle cycle_issue = '{issue: 1'b1, default: 1'b0};

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// decoded instruction.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef struct packed {
		insn_kind kind;
		logic     writeback;
		alu_op    op;
	} insn_ctrl;

	typedef struct packed {
		reg_num      rd;
		reg_num      rn;
		reg_num      rm;
		reg_num      rlo;
		word         imm;
		logic        imm_valid;
		logic [15:0] reg_list;
	} insn_data;

	typedef struct packed {
		logic update_flags;
	} insn_psr;

	typedef struct packed {
		insn_ctrl ctrl;
		insn_data data;
		insn_psr  psr;
	} insn_decode;

endpackage

// ==== verilog/core_alu.sv ====
`timescale 1ns/1ps

module core_alu import core_pkg::*; (
	input  alu_op    op,
	input  word      a,
	input  word      b,
	input  logic     c_in,
	output word      q,
	output psr_flags q_flags,
	output word      mul_hi,
	output word      mul_lo
);

	logic [32:0] sum;
	logic [63:0] product;

	assign product = {32'd0, a} * {32'd0, b};
	assign mul_hi = product[63:32];
	assign mul_lo = product[31:0];

	always_comb begin
		sum = '0;
		q = '0;
		q_flags = '0;
		q_flags.c = c_in;

		case (op)
			alu_add: begin
				sum = {1'b0, a} + {1'b0, b};
				q = sum[31:0];
				q_flags.c = sum[32];
				q_flags.v = (a[31] == b[31]) && (q[31] != a[31]);
			end
			alu_sub: begin
				// carry set means no borrow.
				sum = {1'b0, a} + {1'b0, ~b} + 33'd1;
				q = sum[31:0];
				q_flags.c = sum[32];
				q_flags.v = (a[31] != b[31]) && (q[31] != a[31]);
			end
			alu_and: q = a & b;
			alu_orr: q = a | b;
			alu_mov: q = b;
			alu_mul: q = product[31:0];
			default: q = '0;
		endcase

		q_flags.n = q[31];
		q_flags.z = (q == '0);
	end

endmodule

// ==== verilog/core_regs.sv ====
`timescale 1ns/1ps

module core_regs import core_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  reg_num   rd,
	input  logic     writeback,
	input  word      wr_value,
	input  reg_num   ra_addr,
	input  reg_num   rb_addr,
	input  reg_num   dbg_addr,
	input  logic     update_flags,
	input  psr_flags wb_flags,
	output word      ra_data,
	output word      rb_data,
	output word      dbg_data,
	output psr_flags flags
);

	word regs [16];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 16; i++)
				regs[i] <= '0;
			flags <= '0;
		end else begin
			if (writeback)
				regs[rd] <= wr_value;
			if (update_flags)
				flags <= wb_flags;
		end
	end

	// combinational reads see a write only after the edge.
	assign ra_data = regs[ra_addr];
	assign rb_data = regs[rb_addr];
	assign dbg_data = regs[dbg_addr];

endmodule

// ==== verilog/core_control_cycle.sv ====
`timescale 1ns/1ps

module core_control_cycle import core_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  insn_decode insn,
	input  logic       insn_valid,
	input  logic       irq,
	input  logic       mem_ready,
	input  logic       pop_valid,
	output ctrl_cycle  cycle,
	output ctrl_cycle  next_cycle,
	output logic       insn_ready,
	output logic       issue,
	output logic       mem_start,
	output insn_decode dec
);

	logic take;

	assign insn_ready = cycle.issue;
	assign take = insn_valid && insn_ready;

	always_comb begin
		next_cycle = '0;
		if (cycle.issue) begin
			if (take) begin
				case (insn.ctrl.kind)
					kind_mul: next_cycle.mul = 1'b1;
					kind_ldm: begin
						// an empty list goes straight to the base write.
						if (|insn.data.reg_list)
							next_cycle.transfer = 1'b1;
						else
							next_cycle.base_writeback = 1'b1;
					end
					default: next_cycle.issue = 1'b1;
				endcase
			end else if (irq && !issue) begin
				// wait until the previous alu result is written.
				next_cycle.exception = 1'b1;
			end else begin
				next_cycle.issue = 1'b1;
			end
		end else if (cycle.transfer) begin
			if (mem_ready && !pop_valid)
				next_cycle.base_writeback = 1'b1;
			else
				next_cycle.transfer = 1'b1;
		end else if (cycle.mul) begin
			next_cycle.mul_hi_wb = 1'b1;
		end else begin
			next_cycle.issue = 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cycle <= cycle_issue;
			issue <= 1'b0;
			mem_start <= 1'b0;
		end else begin
			cycle <= next_cycle;
			issue <= take;
			// one pulse at the start of every memory access.
			mem_start <= next_cycle.transfer && (!cycle.transfer || mem_ready);
		end
	end

	always_ff @(posedge clk) begin
		if (take)
			dec <= insn;
	end

endmodule

// ==== verilog/core_control_ldst.sv ====
`timescale 1ns/1ps

module core_control_ldst import core_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  ctrl_cycle  cycle,
	input  ctrl_cycle  next_cycle,
	input  insn_decode dec,
	input  word        base,
	input  logic       mem_ready,
	output reg_num     popped,
	output logic       pop_valid,
	output word        saved_base,
	output word        mem_addr
);

	logic        first;
	logic [15:0] remaining;
	logic [15:0] list_cur;
	logic [15:0] list_next;
	word         addr_q;

	// first transfer starts from the decoded list and the base register.
	assign list_cur = first ? dec.data.reg_list : remaining;
	assign mem_addr = first ? base : addr_q;
	assign saved_base = first ? base : addr_q;

	// lowest set bit wins.
	always_comb begin
		popped = '0;
		for (int i = 15; i >= 0; i--) begin
			if (list_cur[i])
				popped = reg_num'(i);
		end
	end

	assign list_next = list_cur & ~(16'd1 << popped);
	assign pop_valid = cycle.transfer && (|list_next);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			first <= 1'b1;
		else if (next_cycle.issue)
			first <= 1'b1;
		else if (cycle.transfer)
			first <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (cycle.transfer) begin
			remaining <= mem_ready ? list_next : list_cur;
			addr_q <= mem_ready ? mem_addr + 32'd4 : mem_addr;
		end
	end

endmodule

// ==== verilog/core_control_writeback.sv ====
`timescale 1ns/1ps

module core_control_writeback import core_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,

	input  insn_decode dec,
	input  psr_flags   alu_flags,
	input  word        q_alu,
	input  word        mem_data_rd,
	input  logic       mem_ready,
	input  word        mul_q_hi,
	input  word        mul_q_lo,

	input  ctrl_cycle  cycle,
	input  ctrl_cycle  next_cycle,
	input  word        saved_base,
	input  word        vector,
	input  reg_num     ra,
	input  reg_num     popped,
	input  reg_num     mul_r_add_hi,
	input  logic       issue,
	input  logic       pop_valid,

	output reg_num     rd,
	output reg_num     final_rd,
	output logic       writeback,
	output logic       final_writeback,
	output logic       update_flags,
	output logic       final_update_flags,
	output word        wr_value,
	output psr_flags   wb_alu_flags
);

	reg_num last_rd;
	word    hi_hold;
	logic   exec;
	logic   irq_entry;

	// first execute cycle of an alu or multiply instruction.
	assign exec = (cycle.issue && issue) || cycle.mul;
	assign irq_entry = cycle.issue && next_cycle.exception;
	assign final_update_flags = exec && dec.psr.update_flags;

	always_comb begin
		rd = last_rd;
		writeback = 1'b0;
		wr_value = q_alu;

		if (cycle.transfer) begin
			rd = popped;
			writeback = mem_ready;
			wr_value = mem_data_rd;
		end else if (exec) begin
			rd = dec.data.rd;
			writeback = cycle.mul || dec.ctrl.writeback;
			if (cycle.mul)
				wr_value = mul_q_lo;
		end else if (irq_entry) begin
			// return address first, then the vector.
			rd = reg_lr;
			writeback = 1'b1;
			wr_value = '0;
		end else if (final_writeback) begin
			writeback = 1'b1;
			if (cycle.base_writeback) begin
				rd = ra;
				wr_value = saved_base;
			end else if (cycle.mul_hi_wb) begin
				rd = final_rd;
				wr_value = hi_hold;
			end else begin
				rd = final_rd;
				wr_value = vector;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			last_rd <= '0;
			final_rd <= '0;
			final_writeback <= 1'b0;
			update_flags <= 1'b0;
		end else begin
			last_rd <= rd;
			update_flags <= final_update_flags;

			if (next_cycle.exception)
				final_rd <= reg_pc;
			else if (next_cycle.mul_hi_wb)
				final_rd <= mul_r_add_hi;

			// the last load hands over to the base write.
			if (cycle.transfer)
				final_writeback <= mem_ready && !pop_valid;
			else
				final_writeback <= next_cycle.base_writeback || next_cycle.mul_hi_wb ||
					next_cycle.exception;
		end
	end

	// high word is held since rd may be one of the operands.
	always_ff @(posedge clk) begin
		wb_alu_flags <= alu_flags;
		if (cycle.mul)
			hi_hold <= mul_q_hi;
	end

endmodule

// ==== verilog/core_control.sv ====
`timescale 1ns/1ps

module core_control import core_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  insn_decode insn,
	input  logic       insn_valid,
	output logic       insn_ready,
	output word        mem_addr,
	output logic       mem_start,
	input  word        mem_data_rd,
	input  logic       mem_ready,
	input  logic       irq,
	input  word        vector,
	input  reg_num     dbg_addr,
	output word        dbg_data,
	output psr_flags   flags
);

	ctrl_cycle  cycle;
	ctrl_cycle  next_cycle;
	insn_decode dec;
	logic       issue;
	reg_num     popped;
	logic       pop_valid;
	word        saved_base;
	word        q_alu;
	psr_flags   alu_flags;
	word        mul_q_hi;
	word        mul_q_lo;
	reg_num     rd;
	logic       writeback;
	word        wr_value;
	logic       update_flags;
	psr_flags   wb_alu_flags;
	word        ra_data;
	word        rb_data;
	word        alu_b;

	// second operand is the immediate or rm.
	assign alu_b = dec.data.imm_valid ? dec.data.imm : rb_data;

	core_control_cycle sequencer (
		.clk, .rst_n, .insn, .insn_valid, .irq, .mem_ready, .pop_valid,
		.cycle, .next_cycle, .insn_ready, .issue, .mem_start, .dec
	);

	core_control_ldst ldst (
		.clk, .rst_n, .cycle, .next_cycle, .dec, .base(ra_data), .mem_ready,
		.popped, .pop_valid, .saved_base, .mem_addr
	);

	core_alu alu (
		.op(dec.ctrl.op), .a(ra_data), .b(alu_b), .c_in(flags.c),
		.q(q_alu), .q_flags(alu_flags), .mul_hi(mul_q_hi), .mul_lo(mul_q_lo)
	);

	core_control_writeback wb_block (
		.clk, .rst_n, .dec, .alu_flags, .q_alu, .mem_data_rd, .mem_ready,
		.mul_q_hi, .mul_q_lo, .cycle, .next_cycle, .saved_base, .vector,
		.ra(dec.data.rn), .popped, .mul_r_add_hi(dec.data.rlo), .issue, .pop_valid,
		.rd, .final_rd(), .writeback, .final_writeback(), .update_flags,
		.final_update_flags(), .wr_value, .wb_alu_flags
	);

	core_regs regs (
		.clk, .rst_n, .rd, .writeback, .wr_value,
		.ra_addr(dec.data.rn), .rb_addr(dec.data.rm), .dbg_addr,
		.update_flags, .wb_flags(wb_alu_flags),
		.ra_data, .rb_data, .dbg_data, .flags
	);

endmodule

// ==== sim/core_control_tb.sv ====
`timescale 1ns/1ps

module core_control_tb import core_pkg::*; ();

	localparam int num_rows = 21;
	localparam int cycle_limit = num_rows * 40;
	localparam word mem_key = 32'h5a3c_96e1;
	localparam word irq_vector = 32'h0000_8000;
	localparam logic [63:0] mul_product = 64'h1234_5678 * 64'h9abc_def0;

	localparam logic [1:0] act_none = 2'd0;
	localparam logic [1:0] act_insn = 2'd1;
	localparam logic [1:0] act_irq = 2'd2;

	typedef struct packed {
		logic [1:0] action;
		insn_decode insn;
		reg_num     check_reg;
		word        expect_word;
		psr_flags   expect_flags;
	} test_row;

	logic       clk;
	logic       rst_n;
	insn_decode insn;
	logic       insn_valid;
	logic       insn_ready;
	word        mem_addr;
	logic       mem_start;
	word        mem_data_rd;
	logic       mem_ready;
	logic       irq;
	word        vector;
	reg_num     dbg_addr;
	word        dbg_data;
	psr_flags   flags;

	test_row     table_rows [num_rows];
	int          errors;
	int          checks;
	int          cycle_count;
	logic [31:0] lfsr_state = 32'h5368;

	core_control uut (
		.clk, .rst_n, .insn, .insn_valid, .insn_ready, .mem_addr, .mem_start,
		.mem_data_rd, .mem_ready, .irq, .vector, .dbg_addr, .dbg_data, .flags
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// helpers.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// taps 32, 22, 2, 1.
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic draw_bits(input int count, output int value);
		value = 0;
		for (int i = 0; i < count; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			value = {value[30:0], lfsr_state[0]};
		end
	endtask

	function automatic word mem_word(input word addr);
		return addr ^ mem_key;
	endfunction

	function automatic insn_decode alu_imm(input alu_op op, input reg_num rd,
			input reg_num rn, input word imm, input logic upd);
		insn_decode d;
		d = '0;
		d.ctrl.kind = kind_alu;
		d.ctrl.writeback = 1'b1;
		d.ctrl.op = op;
		d.data.rd = rd;
		d.data.rn = rn;
		d.data.imm = imm;
		d.data.imm_valid = 1'b1;
		d.psr.update_flags = upd;
		return d;
	endfunction

	function automatic insn_decode alu_reg(input alu_op op, input reg_num rd,
			input reg_num rn, input reg_num rm, input logic upd);
		insn_decode d;
		d = alu_imm(op, rd, rn, '0, upd);
		d.data.rm = rm;
		d.data.imm_valid = 1'b0;
		return d;
	endfunction

	function automatic insn_decode mul_imm(input reg_num rd, input reg_num rlo,
			input reg_num rn, input word imm);
		insn_decode d;
		d = alu_imm(alu_mul, rd, rn, imm, 1'b0);
		d.ctrl.kind = kind_mul;
		d.data.rlo = rlo;
		return d;
	endfunction

	function automatic insn_decode ldm(input reg_num rn, input logic [15:0] list);
		insn_decode d;
		d = '0;
		d.ctrl.kind = kind_ldm;
		d.ctrl.writeback = 1'b1;
		d.data.rn = rn;
		d.data.reg_list = list;
		return d;
	endfunction

	task automatic compare_value(input word got, input word expected, input string what);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, expected);
		end
	endtask

	task automatic wait_cycle();
		@(posedge clk);
		#2;
	endtask

	task automatic wait_ready();
		while (!insn_ready)
			wait_cycle();
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stimulus table.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic fill_table();
		table_rows[0] = '{act_insn, alu_imm(alu_mov, 4'd1, 4'd0, 32'h7fff_ffff, 1'b0),
			4'd1, 32'h7fff_ffff, 4'b0000};
		// signed overflow into bit 31.
		table_rows[1] = '{act_insn, alu_imm(alu_add, 4'd2, 4'd1, 32'd1, 1'b1),
			4'd2, 32'h8000_0000, 4'b1001};
		table_rows[2] = '{act_insn, alu_reg(alu_sub, 4'd3, 4'd2, 4'd2, 1'b1),
			4'd3, 32'd0, 4'b0110};
		table_rows[3] = '{act_insn, alu_imm(alu_mov, 4'd5, 4'd0, 32'hffff_ffff, 1'b0),
			4'd5, 32'hffff_ffff, 4'b0110};
		table_rows[4] = '{act_insn, alu_imm(alu_add, 4'd4, 4'd5, 32'd2, 1'b1),
			4'd4, 32'd1, 4'b0010};
		table_rows[5] = '{act_insn, alu_imm(alu_add, 4'd6, 4'd4, 32'd5, 1'b0),
			4'd6, 32'd6, 4'b0010};
		// borrow clears c.
		table_rows[6] = '{act_insn, alu_imm(alu_sub, 4'd7, 4'd4, 32'd2, 1'b1),
			4'd7, 32'hffff_ffff, 4'b1000};
		table_rows[7] = '{act_insn, alu_imm(alu_mov, 4'd8, 4'd0, 32'h1234_5678, 1'b0),
			4'd8, 32'h1234_5678, 4'b1000};
		table_rows[8] = '{act_insn, mul_imm(4'd9, 4'd10, 4'd8, 32'h9abc_def0),
			4'd9, mul_product[31:0], 4'b1000};
		table_rows[9] = '{act_none, '0, 4'd10, mul_product[63:32], 4'b1000};
		table_rows[10] = '{act_insn, alu_imm(alu_mov, 4'd11, 4'd0, 32'h1000, 1'b0),
			4'd11, 32'h1000, 4'b1000};
		// r0, r2, r5 and r12 from ascending addresses.
		table_rows[11] = '{act_insn, ldm(4'd11, 16'h1025), 4'd0, mem_word(32'h1000), 4'b1000};
		table_rows[12] = '{act_none, '0, 4'd2, mem_word(32'h1004), 4'b1000};
		table_rows[13] = '{act_none, '0, 4'd5, mem_word(32'h1008), 4'b1000};
		table_rows[14] = '{act_none, '0, 4'd12, mem_word(32'h100c), 4'b1000};
		table_rows[15] = '{act_none, '0, 4'd11, 32'h1010, 4'b1000};
		table_rows[16] = '{act_insn, ldm(4'd11, 16'h0008), 4'd3, mem_word(32'h1010), 4'b1000};
		table_rows[17] = '{act_none, '0, 4'd11, 32'h1014, 4'b1000};
		table_rows[18] = '{act_insn, alu_imm(alu_mov, 4'd14, 4'd0, 32'h55, 1'b0),
			4'd14, 32'h55, 4'b1000};
		table_rows[19] = '{act_irq, '0, 4'd14, 32'd0, 4'b1000};
		table_rows[20] = '{act_none, '0, 4'd15, irq_vector, 4'b1000};
	endtask

	task automatic apply_row(input test_row row);
		wait_cycle();
		if (row.action != act_none) begin
			wait_ready();
			if (row.action == act_irq) begin
				irq = 1'b1;
				wait_cycle();
				irq = 1'b0;
			end else begin
				insn = row.insn;
				insn_valid = 1'b1;
				wait_cycle();
				insn_valid = 1'b0;
			end
			// flags land two edges after the issue edge.
			repeat (3) wait_cycle();
			wait_ready();
		end
		dbg_addr = row.check_reg;
		#1;
		compare_value(dbg_data, row.expect_word, $sformatf("r%0d", row.check_reg));
		compare_value({28'd0, flags}, {28'd0, row.expect_flags}, "flags");
	endtask

	task automatic check_reset_state();
		compare_value({31'd0, insn_ready}, 32'd1, "insn_ready after reset");
		compare_value({28'd0, flags}, 32'd0, "flags after reset");
		for (int r = 0; r < 16; r++) begin
			wait_cycle();
			dbg_addr = reg_num'(r);
			#1;
			compare_value(dbg_data, 32'd0, $sformatf("r%0d after reset", r));
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// memory model and run control.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	initial begin
		int   waits;
		logic active;
		mem_ready = 1'b0;
		mem_data_rd = '0;
		waits = 0;
		active = 1'b0;
		forever begin
			wait_cycle();
			// each access gets 0 to 3 wait cycles.
			if (mem_start) begin
				// a new access starts only after the previous one was answered.
				compare_value({31'd0, active}, 32'd0, "access pending at mem_start");
				draw_bits(2, waits);
				active = 1'b1;
			end
			mem_ready = 1'b0;
			if (active) begin
				if (waits == 0) begin
					mem_ready = 1'b1;
					mem_data_rd = mem_word(mem_addr);
					active = 1'b0;
				end else begin
					waits--;
				end
			end
		end
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < cycle_limit) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("run stopped: no finish after %0d clock cycles", cycle_limit);
		$display("checks: %0d  errors: %0d", checks, errors);
		$display(">>> FAIL");
		$finish;
	end

	initial begin
		rst_n = 1'b0;
		insn = '0;
		insn_valid = 1'b0;
		irq = 1'b0;
		vector = irq_vector;
		dbg_addr = '0;
		errors = 0;
		checks = 0;
		fill_table();

		repeat (10) @(posedge clk);
		#2;
		rst_n = 1'b1;
		check_reset_state();

		for (int i = 0; i < num_rows; i++)
			apply_row(table_rows[i]);
		wait_cycle();

		$display("checks: %0d  errors: %0d", checks, errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

// ==== build.f ====
verilog/core_pkg.sv
verilog/core_alu.sv
verilog/core_regs.sv
verilog/core_control_cycle.sv
verilog/core_control_ldst.sv
verilog/core_control_writeback.sv
verilog/core_control.sv
sim/core_control_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only --timing
TOP       ?= core_control_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q ">>> PASS" $(LOG) || (echo "simulation ended without a result"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
